// File: common/soc_pkg.sv
package soc_pkg;

    // system bus data and address words
    typedef logic [63:0] xlen_t;
    typedef logic [63:0] addr_t;

    // bits [1:0] give the access size, bit 2 marks unsigned loads
    // stores reuse codes 000 to 011 as sb, sh, sw, sd
    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        ld  = 3'b011,
        lbu = 3'b100,
        lhu = 3'b101,
        lwu = 3'b110
    } ls_type_e;

    // one bus request, held stable by the requester until done
    typedef struct packed {
        addr_t    addr;
        xlen_t    wdata;
        ls_type_e ls_type;
        logic     is_write;
    } bus_req_t;

    // target latched by the router for the access in flight
    typedef enum logic [1:0] {
        tgt_none,
        tgt_ram,
        tgt_plic
    } target_e;

    typedef logic [2:0] prio_t;

    // interrupt ids that own a priority register
    localparam int NUM_PRIO = 5;

    // controller configuration, context 0 is machine, context 1 supervisor
    typedef struct packed {
        prio_t [NUM_PRIO:1] prio;
        logic  [1:0][31:0]  enable;
        prio_t [1:0]        thresh;
    } plic_cfg_t;

    // address map
    localparam addr_t RAM_BASE  = 32'h8000_0000;
    localparam addr_t PLIC_BASE = 32'h0C00_0000;
    localparam addr_t PLIC_SPAN = 'h40_0000;

    // register offsets inside the interrupt controller window
    localparam int unsigned PLIC_PENDING_OFS   = 'h1000;
    localparam int unsigned PLIC_ENABLE_OFS    = 'h2000;
    localparam int unsigned PLIC_ENABLE_STRIDE = 'h80;
    localparam int unsigned PLIC_THRESH_OFS    = 'h20_0000;
    localparam int unsigned PLIC_CLAIM_OFS     = 'h20_0004;
    localparam int unsigned PLIC_CTX_STRIDE    = 'h1000;

endpackage

// File: ram/data_ram.sv
`timescale 1ns/1ns

module data_ram #(
    parameter int RAM_WORDS = 2048
) (
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  logic              stb,
    input  soc_pkg::bus_req_t req,
    output logic              ack,
    output soc_pkg::xlen_t    rdata
);
    import soc_pkg::*;

    localparam int AW = $clog2(RAM_WORDS);

    logic [31:0]   mem [RAM_WORDS];
    logic [AW-1:0] idx;
    logic [AW-1:0] beat_idx;
    logic [1:0]    lane;
    logic          beat;
    logic          dbl;
    logic [31:0]   word;
    logic [31:0]   sh_word;
    xlen_t         load_val;
    logic [3:0]    be;
    logic [31:0]   wword;
    logic [2:0]    size_mask;

    // base is aligned well above the window, low bits are the offset
    assign idx  = req.addr[AW+1:2];
    assign lane = req.addr[1:0];
    // ld and sd share code 011
    assign dbl  = (req.ls_type == ld);

    assign word    = mem[idx];
    assign sh_word = word >> {lane, 3'b000};

    // lane select then extension
    always_comb begin
        case (req.ls_type)
            lb:      load_val = {{56{sh_word[7]}}, sh_word[7:0]};
            lh:      load_val = {{48{sh_word[15]}}, sh_word[15:0]};
            lw:      load_val = {{32{sh_word[31]}}, sh_word};
            lbu:     load_val = {56'b0, sh_word[7:0]};
            lhu:     load_val = {48'b0, sh_word[15:0]};
            lwu:     load_val = {32'b0, sh_word};
            // ld low word, the high word follows next beat
            default: load_val = {32'b0, word};
        endcase
    end

    // byte enables, store data replicated over the lanes
    always_comb begin
        case (req.ls_type[1:0])
            2'b00: begin
                be    = 4'b0001 << lane;
                wword = {4{req.wdata[7:0]}};
            end
            2'b01: begin
                be    = 4'b0011 << lane;
                wword = {2{req.wdata[15:0]}};
            end
            default: begin
                be    = 4'b1111;
                wword = req.wdata[31:0];
            end
        endcase
    end

    // word array and read data
    always_ff @(posedge CLOCK_50) begin
        if (beat) begin
            // second word of ld or sd, req is still held
            if (req.is_write) begin
                mem[beat_idx] <= req.wdata[63:32];
            end else begin
                rdata[63:32] <= mem[beat_idx];
            end
        end else if (stb) begin
            if (req.is_write) begin
                for (int b = 0; b < 4; b++) begin
                    if (be[b]) begin
                        mem[idx][8*b +: 8] <= wword[8*b +: 8];
                    end
                end
            end else begin
                rdata <= load_val;
            end
            beat_idx <= idx + 1'b1;
        end
    end

    // single access acks after one cycle, double after two
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            ack  <= 1'b0;
            beat <= 1'b0;
        end else begin
            beat <= stb && dbl;
            ack  <= (stb && !dbl) || beat;
        end
    end

    // 1, 2, 4 or 8 byte alignment
    assign size_mask = 3'((4'd1 << req.ls_type[1:0]) - 4'd1);

    a_aligned: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        stb |-> (req.addr[2:0] & size_mask) == 3'b000);

endmodule

// File: plic/plic_regs.sv
`timescale 1ns/1ns

module plic_regs #(
    parameter int NUM_SRC = 5
) (
    input  logic               CLOCK_50,
    input  logic               KEY0,
    input  logic               stb,
    input  soc_pkg::bus_req_t  req,
    input  logic [NUM_SRC-1:0] irq_src,
    input  logic [1:0][4:0]    claim_id,
    output logic               ack,
    output soc_pkg::xlen_t     rdata,
    output soc_pkg::plic_cfg_t cfg,
    output logic [31:0]        pending
);
    import soc_pkg::*;

    logic [21:0]        ofs;
    logic [9:0]         prio_id;
    logic               prio_hit;
    logic               pend_hit;
    logic [1:0]         en_hit;
    logic [1:0]         th_hit;
    logic [1:0]         cl_hit;
    logic               rd;
    logic               wr;
    logic [NUM_SRC-1:0] irq_q;
    logic [31:0]        set_vec;
    logic [31:0]        clr_vec;
    xlen_t              rd_val;

    // offset inside the 4 MB window
    assign ofs      = 22'(req.addr - PLIC_BASE);
    assign prio_id  = ofs[11:2];
    assign prio_hit = ofs < 22'(PLIC_PENDING_OFS);
    assign pend_hit = ofs == 22'(PLIC_PENDING_OFS);
    assign rd       = stb && !req.is_write;
    assign wr       = stb && req.is_write;

    // per context register decode
    always_comb begin
        for (int c = 0; c < 2; c++) begin
            en_hit[c] = ofs == 22'(PLIC_ENABLE_OFS + c * PLIC_ENABLE_STRIDE);
            th_hit[c] = ofs == 22'(PLIC_THRESH_OFS + c * PLIC_CTX_STRIDE);
            cl_hit[c] = ofs == 22'(PLIC_CLAIM_OFS + c * PLIC_CTX_STRIDE);
        end
    end

    // rising source edges, shifted so source 0 is id 1
    assign set_vec = 32'({irq_src & ~irq_q, 1'b0});

    // claim read retires the id it returns
    always_comb begin
        clr_vec = '0;
        for (int c = 0; c < 2; c++) begin
            if (rd && cl_hit[c]) begin
                clr_vec = clr_vec | (32'd1 << claim_id[c]);
            end
        end
    end

    // read mux
    always_comb begin
        rd_val = '0;
        if (prio_hit) begin
            for (int i = 1; i <= NUM_PRIO; i++) begin
                if (prio_id == 10'(i)) begin
                    rd_val = xlen_t'(cfg.prio[i]);
                end
            end
        end else if (pend_hit) begin
            rd_val = xlen_t'(pending);
        end
        for (int c = 0; c < 2; c++) begin
            if (en_hit[c]) begin
                rd_val = xlen_t'(cfg.enable[c]);
            end
            if (th_hit[c]) begin
                rd_val = xlen_t'(cfg.thresh[c]);
            end
            if (cl_hit[c]) begin
                rd_val = xlen_t'(claim_id[c]);
            end
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            cfg     <= '0;
            pending <= '0;
            irq_q   <= '0;
            ack     <= 1'b0;
        end else begin
            irq_q <= irq_src;
            ack   <= stb;
            // a new edge wins over a claim of the same id, id 0 never pends
            pending <= ((pending & ~clr_vec) | set_vec) & ~32'd1;
            if (wr) begin
                if (prio_hit) begin
                    for (int i = 1; i <= NUM_PRIO; i++) begin
                        if (prio_id == 10'(i)) begin
                            cfg.prio[i] <= req.wdata[2:0];
                        end
                    end
                end
                // pending and claim writes fall through and are dropped
                for (int c = 0; c < 2; c++) begin
                    if (en_hit[c]) begin
                        cfg.enable[c] <= req.wdata[31:0];
                    end
                    if (th_hit[c]) begin
                        cfg.thresh[c] <= req.wdata[2:0];
                    end
                end
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (stb) begin
            rdata <= rd_val;
        end
    end

endmodule

// File: plic/plic_arbiter.sv
`timescale 1ns/1ns

module plic_arbiter #(
    parameter int NUM_SRC = 5
) (
    input  soc_pkg::plic_cfg_t cfg,
    input  logic [31:0]        pending,
    output logic [1:0][4:0]    claim_id,
    output logic               meip,
    output logic               seip
);
    import soc_pkg::*;

    prio_t [31:0] prio_full;

    // ids without a priority register sit at 0 and never fire
    always_comb begin
        prio_full = '0;
        for (int i = 1; i <= NUM_PRIO; i++) begin
            prio_full[i] = cfg.prio[i];
        end
    end

    // best id per context, strict compare keeps the lower id on a tie
    always_comb begin : scan
        prio_t best;
        for (int c = 0; c < 2; c++) begin
            // threshold is the bar to beat
            best        = cfg.thresh[c];
            claim_id[c] = '0;
            for (int i = 1; i <= NUM_SRC; i++) begin
                if (pending[i] && cfg.enable[c][i] && prio_full[i] > best) begin
                    best        = prio_full[i];
                    claim_id[c] = 5'(i);
                end
            end
        end
    end

    // machine and supervisor external interrupt lines
    assign meip = |claim_id[0];
    assign seip = |claim_id[1];

endmodule

// File: rtl/bus_router.sv
`timescale 1ns/1ns

module bus_router #(
    parameter int RAM_WORDS = 2048
) (
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  soc_pkg::bus_req_t req,
    input  logic              rd_stb,
    input  logic              wr_stb,
    output logic              ram_stb,
    output logic              plic_stb,
    input  logic              ram_ack,
    input  soc_pkg::xlen_t    ram_rdata,
    input  logic              plic_ack,
    input  soc_pkg::xlen_t    plic_rdata,
    output soc_pkg::xlen_t    rdata,
    output logic              done
);
    import soc_pkg::*;

    logic    stb;
    logic    ram_hit;
    logic    plic_hit;
    target_e tgt;

    assign stb = rd_stb | wr_stb;

    // address windows
    assign ram_hit  = (req.addr >= RAM_BASE) &&
                      (req.addr < RAM_BASE + (addr_t'(RAM_WORDS) << 2));
    assign plic_hit = (req.addr >= PLIC_BASE) && (req.addr < PLIC_BASE + PLIC_SPAN);

    // strobe goes to the selected target only
    assign ram_stb  = stb & ram_hit;
    assign plic_stb = stb & plic_hit;

    // done drops on the strobe, rises on the target ack
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            done <= 1'b1;
            tgt  <= tgt_none;
        end else if (stb) begin
            done <= 1'b0;
            if (ram_hit) begin
                tgt <= tgt_ram;
            end else if (plic_hit) begin
                tgt <= tgt_plic;
            end else begin
                tgt <= tgt_none;
            end
        end else if (!done) begin
            case (tgt)
                tgt_ram:  done <= ram_ack;
                tgt_plic: done <= plic_ack;
                // unmapped, finish on our own
                default:  done <= 1'b1;
            endcase
        end
    end

    // read data held from completion until the next strobe
    always_ff @(posedge CLOCK_50) begin
        if (!done) begin
            case (tgt)
                tgt_ram: begin
                    if (ram_ack) begin
                        rdata <= ram_rdata;
                    end
                end
                tgt_plic: begin
                    if (plic_ack) begin
                        rdata <= plic_rdata;
                    end
                end
                default: rdata <= '0;
            endcase
        end
    end

    // requester waits for done before the next strobe
    a_no_stb_busy: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (rd_stb || wr_stb) |-> done);

    // windows must never overlap
    a_one_target: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        !(ram_stb && plic_stb));

    // targets take the direction from req, so it has to agree with the strobe
    a_dir_match: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (rd_stb || wr_stb) |-> (req.is_write == wr_stb) && !(rd_stb && wr_stb));

endmodule

// File: rtl/bus_soc.sv
`timescale 1ns/1ns

module bus_soc #(
    parameter int RAM_WORDS = 2048,
    parameter int NUM_SRC   = 5
) (
    input  logic               CLOCK_50,
    input  logic               KEY0,
    input  soc_pkg::bus_req_t  req,
    input  logic               rd_stb,
    input  logic               wr_stb,
    input  logic [NUM_SRC-1:0] irq_src,
    output soc_pkg::xlen_t     rdata,
    output logic               done,
    output logic               meip,
    output logic               seip
);
    import soc_pkg::*;

    logic            ram_stb;
    logic            plic_stb;
    logic            ram_ack;
    logic            plic_ack;
    xlen_t           ram_rdata;
    xlen_t           plic_rdata;
    plic_cfg_t       cfg;
    logic [31:0]     pending;
    logic [1:0][4:0] claim_id;

    // decode and done handshake
    bus_router #(.RAM_WORDS(RAM_WORDS)) u_router (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .req        (req),
        .rd_stb     (rd_stb),
        .wr_stb     (wr_stb),
        .ram_stb    (ram_stb),
        .plic_stb   (plic_stb),
        .ram_ack    (ram_ack),
        .ram_rdata  (ram_rdata),
        .plic_ack   (plic_ack),
        .plic_rdata (plic_rdata),
        .rdata      (rdata),
        .done       (done)
    );

    data_ram #(.RAM_WORDS(RAM_WORDS)) u_ram (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .stb      (ram_stb),
        .req      (req),
        .ack      (ram_ack),
        .rdata    (ram_rdata)
    );

    // interrupt controller, registers plus combinational pick
    plic_regs #(.NUM_SRC(NUM_SRC)) u_plic_regs (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .stb      (plic_stb),
        .req      (req),
        .irq_src  (irq_src),
        .claim_id (claim_id),
        .ack      (plic_ack),
        .rdata    (plic_rdata),
        .cfg      (cfg),
        .pending  (pending)
    );

    plic_arbiter #(.NUM_SRC(NUM_SRC)) u_plic_arb (
        .cfg      (cfg),
        .pending  (pending),
        .claim_id (claim_id),
        .meip     (meip),
        .seip     (seip)
    );

endmodule

// File: bench/tb_bus_tasks.svh
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

// byte model of the first 64 bytes of RAM, little endian
logic [7:0]  ram_model [0:63];

// shadow of the interrupt controller state
prio_t       prio_m [1:5];
logic [31:0] en_m [0:1];
prio_t       th_m [0:1];
logic [31:0] pend_m;

// sd shares code 011 with ld
function automatic void store_model(input int ofs, input ls_type_e t, input xlen_t data);
    int nbytes;
    nbytes = 1 << t[1:0];
    for (int b = 0; b < nbytes; b++) begin
        ram_model[ofs + b] = data[8*b +: 8];
    end
endfunction

// gather bytes, then extend unless bit 2 marks unsigned
function automatic xlen_t load_expect(input int ofs, input ls_type_e t);
    int    nbytes;
    xlen_t v;
    nbytes = 1 << t[1:0];
    v = '0;
    for (int b = nbytes - 1; b >= 0; b--) begin
        v = (v << 8) | xlen_t'(ram_model[ofs + b]);
    end
    if (!t[2] && nbytes < 8 && v[8*nbytes-1]) begin
        v = v | (~64'd0 << (8 * nbytes));
    end
    return v;
endfunction

// top eligible priority first, then the lowest id holding it
function automatic xlen_t claim_expect(input int ctx);
    prio_t top;
    top = th_m[ctx];
    for (int i = 1; i <= 5; i++) begin
        if (pend_m[i] && en_m[ctx][i] && prio_m[i] > top) begin
            top = prio_m[i];
        end
    end
    if (top == th_m[ctx]) begin
        return '0;
    end
    for (int i = 1; i <= 5; i++) begin
        if (pend_m[i] && en_m[ctx][i] && prio_m[i] == top) begin
            return xlen_t'(i);
        end
    end
    return '0;
endfunction

task automatic check_value(input xlen_t got, input xlen_t exp, input string what);
    assert (got === exp) else begin
        mismatch_count++;
        $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    end
endtask

// one strobe, then wait for done and check the cycle count
task automatic bus_access(input addr_t addr, input ls_type_e t, input logic wr,
                          input xlen_t wdata, output xlen_t data);
    bus_req_t r;
    int       cycles;
    int       want;
    r.addr     = addr;
    r.wdata    = wdata;
    r.ls_type  = t;
    r.is_write = wr;
    // only a RAM double access takes the second beat
    want = (addr >= RAM_BASE && addr < RAM_BASE + 4 * RAM_WORDS && t == ld) ? 2 : 1;
    @(posedge CLOCK_50);
    req    <= r;
    rd_stb <= !wr;
    wr_stb <= wr;
    @(posedge CLOCK_50);
    rd_stb <= 1'b0;
    wr_stb <= 1'b0;
    cycles = 0;
    @(negedge CLOCK_50);
    while (!done) begin
        @(negedge CLOCK_50);
        cycles++;
    end
    assert (cycles == want) else begin
        other_count++;
        $display("access to %h finished after %0d cycles instead of %0d", addr, cycles, want);
    end
    data = rdata;
endtask

task automatic bus_write(input addr_t addr, input ls_type_e t, input xlen_t wdata);
    xlen_t unused;
    bus_access(addr, t, 1'b1, wdata, unused);
endtask

task automatic read_check(input addr_t addr, input ls_type_e t, input xlen_t exp,
                          input string what);
    xlen_t got;
    bus_access(addr, t, 1'b0, '0, got);
    check_value(got, exp, what);
endtask

// claim read retires the id in the model too
task automatic claim_check(input int ctx);
    xlen_t exp;
    exp = claim_expect(ctx);
    read_check(PLIC_BASE + PLIC_CLAIM_OFS + ctx * PLIC_CTX_STRIDE, lwu, exp, "claim id");
    pend_m[exp[4:0]] = 1'b0;
endtask

`endif

// File: bench/tb_bus_soc.sv
`timescale 1ns/1ns

module tb_bus_soc;
    import soc_pkg::*;

    localparam int RAM_WORDS = 2048;
    localparam int NUM_SRC   = 5;
    // upper bound on bus accesses in the run
    localparam int NUM_TRANS = 110;

    logic               CLOCK_50;
    logic               KEY0;
    bus_req_t           req;
    logic               rd_stb;
    logic               wr_stb;
    logic [NUM_SRC-1:0] irq_src;
    xlen_t              rdata;
    logic               done;
    logic               meip;
    logic               seip;

    int     mismatch_count = 0;
    int     other_count    = 0;
    integer seed           = 32'hd791_3fcd;

    `include "tb_bus_tasks.svh"

    bus_soc #(
        .RAM_WORDS (RAM_WORDS),
        .NUM_SRC   (NUM_SRC)
    ) uut (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .req      (req),
        .rd_stb   (rd_stb),
        .wr_stb   (wr_stb),
        .irq_src  (irq_src),
        .rdata    (rdata),
        .done     (done),
        .meip     (meip),
        .seip     (seip)
    );

    // 8 ns period
    always #4 CLOCK_50 = ~CLOCK_50;

    // done low for at most two cycles
    a_done_back: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (!done && !$past(done)) |=> done)
        else begin
            other_count++;
            $display("done stayed low for more than two cycles at %0t", $time);
        end

    // context 1 never enabled while sources pend
    a_seip_quiet: assert property (@(posedge CLOCK_50) disable iff (!KEY0) !seip)
        else begin
            other_count++;
            $display("supervisor interrupt raised at %0t", $time);
        end

    initial begin : watchdog
        repeat (NUM_TRANS * 200 + 1000) @(posedge CLOCK_50);
        $display("watchdog expired before the bus accesses finished");
        $display("TEST FAILED");
        $finish;
    end

    initial begin : main
        xlen_t       v;
        logic [31:0] rnd;
        ls_type_e    t;
        int          ofs;
        CLOCK_50 = 1'b0;
        KEY0     = 1'b0;
        req      = '0;
        rd_stb   = 1'b0;
        wr_stb   = 1'b0;
        irq_src  = '0;
        pend_m   = '0;
        repeat (16) @(posedge CLOCK_50);
        KEY0 <= 1'b1;
        @(negedge CLOCK_50);
        check_value(xlen_t'(done), 1, "done after reset");
        check_value(xlen_t'({meip, seip}), 0, "interrupt lines after reset");

        // fill the test window with sd so no byte is unknown
        for (int k = 0; k < 8; k++) begin
            v = {$random(seed), $random(seed)};
            bus_write(RAM_BASE + 8 * k, ld, v);
            store_model(8 * k, ld, v);
        end
        // random sb, sh, sw, sd at aligned offsets
        for (int k = 0; k < 24; k++) begin
            rnd = $random(seed);
            t   = ls_type_e'({1'b0, rnd[1:0]});
            ofs = int'(rnd[13:8]) & ~((1 << t[1:0]) - 1);
            v   = {$random(seed), $random(seed)};
            bus_write(RAM_BASE + ofs, t, v);
            store_model(ofs, t, v);
        end
        // every load type in turn
        for (int k = 0; k < 35; k++) begin
            rnd = $random(seed);
            t   = ls_type_e'(3'(k % 7));
            ofs = int'(rnd[5:0]) & ~((1 << t[1:0]) - 1);
            read_check(RAM_BASE + ofs, t, load_expect(ofs, t), "ram load");
        end

        // lw code doubles as sw for word stores
        // unmapped address
        bus_write(64'h4000_0000, lw, 64'hdead_beef);
        read_check(64'h4000_0000, lw, '0, "unmapped read");

        // register readback, priorities keep 3 bits
        for (int i = 1; i <= 5; i++) begin
            rnd = $random(seed);
            bus_write(PLIC_BASE + 4 * i, lw, xlen_t'(rnd));
            prio_m[i] = rnd[2:0];
        end
        for (int i = 1; i <= 5; i++) begin
            read_check(PLIC_BASE + 4 * i, lwu, xlen_t'(prio_m[i]), "priority");
        end
        for (int c = 0; c < 2; c++) begin
            rnd = $random(seed);
            bus_write(PLIC_BASE + PLIC_ENABLE_OFS + c * PLIC_ENABLE_STRIDE, lw, xlen_t'(rnd));
            en_m[c] = rnd;
            rnd = $random(seed);
            bus_write(PLIC_BASE + PLIC_THRESH_OFS + c * PLIC_CTX_STRIDE, lw, xlen_t'(rnd));
            th_m[c] = rnd[2:0];
        end
        for (int c = 0; c < 2; c++) begin
            read_check(PLIC_BASE + PLIC_ENABLE_OFS + c * PLIC_ENABLE_STRIDE, lwu,
                       xlen_t'(en_m[c]), "enable mask");
            read_check(PLIC_BASE + PLIC_THRESH_OFS + c * PLIC_CTX_STRIDE, lwu,
                       xlen_t'(th_m[c]), "threshold");
        end

        // ids 2 and 4, id 4 higher, machine context only
        for (int i = 1; i <= 5; i++) begin
            prio_m[i] = (i == 4) ? 3'd5 : (i == 2) ? 3'd2 : 3'd0;
            bus_write(PLIC_BASE + 4 * i, lw, xlen_t'(prio_m[i]));
        end
        en_m[0] = 32'h14;
        en_m[1] = 32'h0;
        th_m[0] = 3'd0;
        th_m[1] = 3'd0;
        for (int c = 0; c < 2; c++) begin
            bus_write(PLIC_BASE + PLIC_ENABLE_OFS + c * PLIC_ENABLE_STRIDE, lw, xlen_t'(en_m[c]));
            bus_write(PLIC_BASE + PLIC_THRESH_OFS + c * PLIC_CTX_STRIDE, lw, xlen_t'(th_m[c]));
        end
        // source bit n is id n+1
        @(posedge CLOCK_50);
        irq_src <= 5'b01010;
        pend_m = 32'h14;
        repeat (2) @(negedge CLOCK_50);
        check_value(xlen_t'({meip, seip}), 2'b10, "meip and seip with ids 2 and 4");
        read_check(PLIC_BASE + PLIC_PENDING_OFS, lwu, xlen_t'(pend_m), "pending");
        claim_check(0);
        claim_check(0);
        check_value(xlen_t'(meip), 0, "meip after both claims");

        // threshold at the top priority blocks everything
        th_m[0] = 3'd5;
        bus_write(PLIC_BASE + PLIC_THRESH_OFS, lw, xlen_t'(th_m[0]));
        @(posedge CLOCK_50);
        irq_src <= '0;
        @(posedge CLOCK_50);
        irq_src <= 5'b01010;
        pend_m = 32'h14;
        repeat (2) @(negedge CLOCK_50);
        check_value(xlen_t'(meip), 0, "meip at threshold");
        read_check(PLIC_BASE + PLIC_PENDING_OFS, lwu, xlen_t'(pend_m), "pending at threshold");
        claim_check(0);

        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+bench
common/soc_pkg.sv
ram/data_ram.sv
plic/plic_regs.sv
plic/plic_arbiter.sv
rtl/bus_router.sv
rtl/bus_soc.sv
bench/tb_bus_soc.sv

// File: Bender.yml
package:
  name: bus_soc

sources:
  - files:
      - common/soc_pkg.sv
      - ram/data_ram.sv
      - plic/plic_regs.sv
      - plic/plic_arbiter.sv
      - rtl/bus_router.sv
      - rtl/bus_soc.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_bus_soc.sv
